// ==== design/div_macros.svh ====
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// ------------------------------------------------------------------------
// Operand widths
// ------------------------------------------------------------------------

// Dividend, also the quotient width
`define DIV_A_WIDTH 16

// Divisor, also the remainder width
`define DIV_B_WIDTH 16

// ------------------------------------------------------------------------
// Pipeline depth
// ------------------------------------------------------------------------

// Total stages, one less of them holds registered iterations
`define DIV_NUM_STAGES 5

`endif

// ==== design/div_mode_pkg.sv ====
package div_mode_pkg;

  // Which operand lends its sign to the remainder
  typedef enum logic {
    REM_SIGN_DIVIDEND = 1'b0,
    REM_SIGN_DIVISOR  = 1'b1
  } rem_mode_e;

  // Per-operation control bits, fixed at the pipe entry
  typedef struct packed {
    logic      tc;
    rem_mode_e rem_mode;
    logic      a_sign;
    logic      b_sign;
    logic      div_zero;
    // Most negative dividend over minus one
    logic      ovf;
  } div_flags_t;

endpackage

// ==== design/div_data_pkg.sv ====
`include "div_macros.svh"

package div_data_pkg;

  // Operand and result vectors
  typedef logic [`DIV_A_WIDTH-1:0] dividend_t;
  typedef logic [`DIV_A_WIDTH-1:0] quot_t;
  typedef logic [`DIV_B_WIDTH-1:0] divisor_t;
  typedef logic [`DIV_B_WIDTH-1:0] rem_t;

  // Partial remainder, extra msb holds the sign
  typedef logic [`DIV_B_WIDTH:0] psum_t;

  // Everything one stage hands to the next
  typedef struct packed {
    psum_t                    psum;
    dividend_t                dq;
    divisor_t                 b_mag;
    dividend_t                a_orig;
    logic                     valid;
    div_mode_pkg::div_flags_t flags;
  } div_payload_t;

  // Final answer
  typedef struct packed {
    quot_t quot;
    rem_t  rem;
    logic  divide_by_0;
  } div_result_t;

endpackage

// ==== design/div_operand_prep.sv ====
`timescale 1ns/1ps
`include "div_macros.svh"

module div_operand_prep (
  input  div_data_pkg::dividend_t    a,
  input  div_data_pkg::divisor_t     b,
  input  logic                       tc,
  input  div_mode_pkg::rem_mode_e    rem_mode,
  input  logic                       in_valid,
  output div_data_pkg::div_payload_t payload
);

  logic                    a_neg;
  logic                    b_neg;
  div_data_pkg::dividend_t a_mag;
  div_data_pkg::divisor_t  b_mag;

  // Signs only matter for two's complement operations
  assign a_neg = tc & a[`DIV_A_WIDTH-1];
  assign b_neg = tc & b[`DIV_B_WIDTH-1];

  // Magnitudes feed the unsigned iteration core
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  always_comb
  begin
    // Iterations start from a zero partial remainder
    payload.psum   = '0;
    payload.dq     = a_mag;
    payload.b_mag  = b_mag;
    payload.a_orig = a;
    payload.valid  = in_valid;

    payload.flags.tc       = tc;
    payload.flags.rem_mode = rem_mode;
    payload.flags.a_sign   = a_neg;
    payload.flags.b_sign   = b_neg;
    payload.flags.div_zero = (b == '0);
    // b of all ones is minus one only when signed, already implied by a_neg
    payload.flags.ovf      = a_neg && (a[`DIV_A_WIDTH-2:0] == '0) && (b == '1);
  end

endmodule

// ==== design/div_stage.sv ====
`timescale 1ns/1ps
`include "div_macros.svh"

module div_stage #(
  parameter int NUM_ITER = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       en,
  input  div_data_pkg::div_payload_t payload_in,
  output div_data_pkg::div_payload_t payload_out
);

  div_data_pkg::div_payload_t payload_nxt;

  // ------------------------------------------------------------------------
  // Non-restoring iterations
  // ------------------------------------------------------------------------

  always_comb
  begin
    div_data_pkg::psum_t     psum;
    div_data_pkg::dividend_t dq;
    div_data_pkg::psum_t     shifted;

    psum = payload_in.psum;
    dq   = payload_in.dq;
    for (int i = 0; i < NUM_ITER; i++)
    begin
      // Next dividend bit comes off the top of dq
      shifted = {psum[`DIV_B_WIDTH-1:0], dq[`DIV_A_WIDTH-1]};
      // Negative remainder adds the divisor back, otherwise subtract
      if (psum[`DIV_B_WIDTH])
        psum = shifted + {1'b0, payload_in.b_mag};
      else
        psum = shifted - {1'b0, payload_in.b_mag};
      // Quotient bit set when the new remainder is non-negative
      dq = {dq[`DIV_A_WIDTH-2:0], ~psum[`DIV_B_WIDTH]};
    end

    payload_nxt      = payload_in;
    payload_nxt.psum = psum;
    payload_nxt.dq   = dq;
  end

  // ------------------------------------------------------------------------
  // Stage register, stalled by en
  // ------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      payload_out <= '0;
    else if (en)
      payload_out <= payload_nxt;
  end

  // A stalled cycle must not disturb anything held in the stage
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    !en |=> $stable(payload_out)
  );

endmodule

// ==== design/div_result_fix.sv ====
`timescale 1ns/1ps
`include "div_macros.svh"

module div_result_fix (
  input  div_data_pkg::div_payload_t payload,
  output div_data_pkg::div_result_t  result,
  output logic                       out_valid
);

  div_mode_pkg::div_flags_t flags;
  div_data_pkg::psum_t      psum_fix;
  div_data_pkg::rem_t       rem_mag;
  div_data_pkg::rem_t       rem_trunc;
  div_data_pkg::rem_t       rem_signed;
  div_data_pkg::quot_t      quot_signed;
  div_data_pkg::quot_t      quot_zero;
  div_data_pkg::rem_t       rem_zero;

  assign flags = payload.flags;

  // ------------------------------------------------------------------------
  // Normal result
  // ------------------------------------------------------------------------

  // Last step can leave the remainder one divisor too low
  assign psum_fix = payload.psum[`DIV_B_WIDTH] ?
                    (payload.psum + {1'b0, payload.b_mag}) : payload.psum;
  assign rem_mag  = psum_fix[`DIV_B_WIDTH-1:0];

  // Quotient negative when the operand signs differ
  assign quot_signed = (flags.a_sign ^ flags.b_sign) ? (~payload.dq + 1'b1) : payload.dq;

  // Truncating remainder follows the dividend
  assign rem_trunc = flags.a_sign ? (~rem_mag + 1'b1) : rem_mag;

  always_comb
  begin
    rem_signed = rem_trunc;
    // Modulus, shift by one divisor when the signs disagree
    if ((flags.rem_mode == div_mode_pkg::REM_SIGN_DIVISOR) && (rem_mag != '0) &&
        (flags.a_sign != flags.b_sign))
      rem_signed = flags.b_sign ? (rem_mag - payload.b_mag) : (payload.b_mag - rem_mag);
  end

  // ------------------------------------------------------------------------
  // Special cases
  // ------------------------------------------------------------------------

  always_comb
  begin
    if (!flags.tc)
      quot_zero = '1;
    else if (flags.a_sign)
      quot_zero = {1'b1, {(`DIV_A_WIDTH-1){1'b0}}};
    else
      quot_zero = {1'b0, {(`DIV_A_WIDTH-1){1'b1}}};
  end

  // Dividend returned as remainder, sign extended when signed
  assign rem_zero = flags.tc ? div_data_pkg::rem_t'($signed(payload.a_orig)) :
                               div_data_pkg::rem_t'(payload.a_orig);

  always_comb
  begin
    result.divide_by_0 = flags.div_zero;
    if (flags.div_zero)
    begin
      result.quot = quot_zero;
      result.rem  = rem_zero;
    end
    else if (flags.ovf)
    begin
      result.quot = payload.a_orig;
      result.rem  = '0;
    end
    else
    begin
      result.quot = quot_signed;
      result.rem  = rem_signed;
    end
  end

  assign out_valid = payload.valid;

  // Flag raised at the pipe entry must still match the divisor carried along
  always_comb
  begin
    if (out_valid)
      a_div0_match: assert #0 (result.divide_by_0 == (payload.b_mag == '0));
  end

endmodule

// ==== design/div_pipe.sv ====
`timescale 1ns/1ps
`include "div_macros.svh"

module div_pipe (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      en,
  input  logic                      in_valid,
  input  div_data_pkg::dividend_t   a,
  input  div_data_pkg::divisor_t    b,
  input  logic                      tc,
  input  div_mode_pkg::rem_mode_e   rem_mode,
  output logic                      out_valid,
  output div_data_pkg::div_result_t result
);

  // Registered iteration stages
  localparam int NUM_REG    = `DIV_NUM_STAGES - 1;
  localparam int BASE_ITER  = `DIV_A_WIDTH / NUM_REG;
  localparam int EXTRA_ITER = `DIV_A_WIDTH % NUM_REG;

  div_data_pkg::div_payload_t pipe [0:NUM_REG];

  div_operand_prep u_prep (
    .a        (a),
    .b        (b),
    .tc       (tc),
    .rem_mode (rem_mode),
    .in_valid (in_valid),
    .payload  (pipe[0])
  );

  // ------------------------------------------------------------------------
  // Iteration stages, leftover bits go to the first few
  // ------------------------------------------------------------------------

  for (genvar s = 0; s < NUM_REG; s++)
  begin : g_stage
    localparam int ITERS = BASE_ITER + ((s < EXTRA_ITER) ? 1 : 0);

    div_stage #(
      .NUM_ITER (ITERS)
    ) u_stage (
      .clk         (clk),
      .rst_n       (rst_n),
      .en          (en),
      .payload_in  (pipe[s]),
      .payload_out (pipe[s+1])
    );
  end

  div_result_fix u_fix (
    .payload   (pipe[NUM_REG]),
    .result    (result),
    .out_valid (out_valid)
  );

  a_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(out_valid)
  );

endmodule

// ==== sim/div_pipe_tb.sv ====
`timescale 1ns/1ps
`include "div_macros.svh"

module div_pipe_tb;

  localparam int TABLE_LEN   = 21;
  localparam int NUM_RANDOM  = 200;
  localparam int CYCLE_LIMIT = (TABLE_LEN + NUM_RANDOM) * 3 + 50;
  localparam int LATENCY     = `DIV_NUM_STAGES - 1;

  localparam div_mode_pkg::rem_mode_e MODE_TRUNC = div_mode_pkg::REM_SIGN_DIVIDEND;
  localparam div_mode_pkg::rem_mode_e MODE_MOD   = div_mode_pkg::REM_SIGN_DIVISOR;

  localparam div_data_pkg::quot_t QUOT_MIN = {1'b1, {(`DIV_A_WIDTH-1){1'b0}}};
  localparam div_data_pkg::quot_t QUOT_MAX = {1'b0, {(`DIV_A_WIDTH-1){1'b1}}};

  typedef struct packed {
    div_data_pkg::dividend_t   a;
    div_data_pkg::divisor_t    b;
    logic                      tc;
    div_mode_pkg::rem_mode_e   rem_mode;
    logic                      en;
    div_data_pkg::div_result_t expected;
  } vector_t;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      en;
  logic                      in_valid;
  div_data_pkg::dividend_t   a;
  div_data_pkg::divisor_t    b;
  logic                      tc;
  div_mode_pkg::rem_mode_e   rem_mode;
  logic                      out_valid;
  div_data_pkg::div_result_t result;

  vector_t                   vectors [0:TABLE_LEN-1];
  div_data_pkg::div_result_t expected_q [$];
  div_data_pkg::div_result_t held_result;
  logic                      held_valid;
  integer                    seed;
  int                        cycle_count = 0;
  int                        result_count = 0;

  div_pipe UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .tc        (tc),
    .rem_mode  (rem_mode),
    .out_valid (out_valid),
    .result    (result)
  );

  always #10 clk = ~clk;

  // ----------------------------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------------------------

  task automatic abort_run;
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_quot(input div_data_pkg::quot_t got, input div_data_pkg::quot_t exp,
                            input string what);
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s quotient is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rem(input div_data_pkg::rem_t got, input div_data_pkg::rem_t exp,
                           input string what);
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s remainder is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s flag is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Reference division built from the rules of the divider
  function automatic div_data_pkg::div_result_t expected_result(
    input div_data_pkg::dividend_t a_v,
    input div_data_pkg::divisor_t  b_v,
    input logic                    tc_v,
    input div_mode_pkg::rem_mode_e mode_v
  );
    div_data_pkg::div_result_t res;
    int sa;
    int sb;
    int q;
    int r;

    res.divide_by_0 = (b_v == '0);
    if (b_v == '0)
    begin
      if (!tc_v)
        res.quot = '1;
      else if (a_v[`DIV_A_WIDTH-1])
        res.quot = QUOT_MIN;
      else
        res.quot = QUOT_MAX;
      res.rem = a_v;
    end
    else if (!tc_v)
    begin
      res.quot = a_v / b_v;
      res.rem  = a_v % b_v;
    end
    else if ((a_v == QUOT_MIN) && (b_v == '1))
    begin
      res.quot = a_v;
      res.rem  = '0;
    end
    else
    begin
      sa = $signed(a_v);
      sb = $signed(b_v);
      // SV integer division already truncates toward zero
      q = sa / sb;
      r = sa % sb;
      if ((mode_v == MODE_MOD) && (r != 0) && ((r < 0) != (sb < 0)))
        r = r + sb;
      res.quot = q[`DIV_A_WIDTH-1:0];
      res.rem  = r[`DIV_B_WIDTH-1:0];
    end
    return res;
  endfunction

  // Called just after a rising edge while en still holds the value that edge saw
  task automatic observe_outputs;
    div_data_pkg::div_result_t exp;
    string                     what;

    if (!en)
    begin
      what = "stalled output";
      check_flag(out_valid, held_valid, what);
      check_quot(result.quot, held_result.quot, what);
      check_rem(result.rem, held_result.rem, what);
      check_flag(result.divide_by_0, held_result.divide_by_0, what);
    end
    else if (out_valid)
    begin
      if (expected_q.size() == 0)
      begin
        $display("Error at %0t ns: out_valid went high with no operation in flight", $time);
        abort_run();
      end
      else
      begin
        exp = expected_q.pop_front();
        result_count++;
        what = $sformatf("result %0d", result_count);
        check_quot(result.quot, exp.quot, what);
        check_rem(result.rem, exp.rem, what);
        check_flag(result.divide_by_0, exp.divide_by_0, what);
      end
    end
    held_valid  = out_valid;
    held_result = result;
  endtask

  task automatic run_cycle(
    input div_data_pkg::dividend_t   a_v,
    input div_data_pkg::divisor_t    b_v,
    input logic                      tc_v,
    input div_mode_pkg::rem_mode_e   mode_v,
    input logic                      en_v,
    input logic                      valid_v,
    input div_data_pkg::div_result_t exp
  );
    a        = a_v;
    b        = b_v;
    tc       = tc_v;
    rem_mode = mode_v;
    en       = en_v;
    in_valid = valid_v;
    if (en_v && valid_v)
      expected_q.push_back(exp);
    @(posedge clk);
    #2;
    observe_outputs();
  endtask

  // ----------------------------------------------------------------------------
  // Directed vectors as a, b, tc, mode, en, quotient, remainder and div0
  // ----------------------------------------------------------------------------

  task automatic load_vectors;
    // Unsigned
    vectors[0]  = '{16'd100, 16'd7, 1'b0, MODE_TRUNC, 1'b1, '{16'd14, 16'd2, 1'b0}};
    vectors[1]  = '{16'hffff, 16'h0001, 1'b0, MODE_TRUNC, 1'b1, '{16'hffff, 16'h0000, 1'b0}};
    vectors[2]  = '{16'd5, 16'd9, 1'b0, MODE_MOD, 1'b1, '{16'd0, 16'd5, 1'b0}};
    vectors[3]  = '{16'hffff, 16'hffff, 1'b0, MODE_TRUNC, 1'b1, '{16'h0001, 16'h0000, 1'b0}};
    vectors[4]  = '{16'd40000, 16'd300, 1'b0, MODE_TRUNC, 1'b1, '{16'd133, 16'd100, 1'b0}};
    vectors[5]  = '{16'd1234, 16'd5, 1'b0, MODE_TRUNC, 1'b0, '{16'h0000, 16'h0000, 1'b0}};
    // Signed, both remainder modes
    vectors[6]  = '{16'hfff9, 16'h0002, 1'b1, MODE_TRUNC, 1'b1, '{16'hfffd, 16'hffff, 1'b0}};
    vectors[7]  = '{16'hfff9, 16'h0002, 1'b1, MODE_MOD, 1'b1, '{16'hfffd, 16'h0001, 1'b0}};
    vectors[8]  = '{16'h0007, 16'hfffe, 1'b1, MODE_TRUNC, 1'b1, '{16'hfffd, 16'h0001, 1'b0}};
    vectors[9]  = '{16'h0007, 16'hfffe, 1'b1, MODE_MOD, 1'b1, '{16'hfffd, 16'hffff, 1'b0}};
    vectors[10] = '{16'hfff9, 16'hfffe, 1'b1, MODE_MOD, 1'b1, '{16'h0003, 16'hffff, 1'b0}};
    vectors[11] = '{16'hfff8, 16'h0002, 1'b1, MODE_MOD, 1'b1, '{16'hfffc, 16'h0000, 1'b0}};
    vectors[12] = '{16'h0000, 16'h0000, 1'b1, MODE_TRUNC, 1'b0, '{16'h0000, 16'h0000, 1'b0}};
    // Divide by zero
    vectors[13] = '{16'h04d2, 16'h0000, 1'b0, MODE_TRUNC, 1'b1, '{16'hffff, 16'h04d2, 1'b1}};
    vectors[14] = '{16'hfffb, 16'h0000, 1'b1, MODE_TRUNC, 1'b1, '{16'h8000, 16'hfffb, 1'b1}};
    vectors[15] = '{16'h0005, 16'h0000, 1'b1, MODE_MOD, 1'b1, '{16'h7fff, 16'h0005, 1'b1}};
    // Most negative over minus one, and its neighbours
    vectors[16] = '{16'h8000, 16'hffff, 1'b1, MODE_TRUNC, 1'b1, '{16'h8000, 16'h0000, 1'b0}};
    vectors[17] = '{16'h8000, 16'hffff, 1'b1, MODE_MOD, 1'b1, '{16'h8000, 16'h0000, 1'b0}};
    vectors[18] = '{16'h8000, 16'hffff, 1'b0, MODE_TRUNC, 1'b1, '{16'h0000, 16'h8000, 1'b0}};
    vectors[19] = '{16'h8000, 16'h0002, 1'b1, MODE_TRUNC, 1'b1, '{16'hc000, 16'h0000, 1'b0}};
    vectors[20] = '{16'h7fff, 16'h8000, 1'b1, MODE_MOD, 1'b1, '{16'h0000, 16'hffff, 1'b0}};
  endtask

  // Run limit
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  // ----------------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------------

  initial
  begin
    div_data_pkg::dividend_t r_a;
    div_data_pkg::divisor_t  r_b;
    logic [31:0]             ctl;

    rst_n    = 1'b0;
    en       = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    tc       = 1'b0;
    rem_mode = MODE_TRUNC;
    seed     = 32'h11b7_405c;
    load_vectors();

    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_flag(out_valid, 1'b0, "out_valid after reset");
    held_valid  = out_valid;
    held_result = result;

    for (int i = 0; i < TABLE_LEN; i++)
      run_cycle(vectors[i].a, vectors[i].b, vectors[i].tc, vectors[i].rem_mode,
                vectors[i].en, 1'b1, vectors[i].expected);

    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      r_a = div_data_pkg::dividend_t'($random(seed));
      r_b = div_data_pkg::divisor_t'($random(seed));
      ctl = $random(seed);
      // Small divisors give long quotients
      if (ctl[4:2] == 3'd0)
        r_b = r_b & 16'h00ff;
      if (ctl[9:5] == 5'd0)
        r_b = '0;
      if (ctl[14:10] == 5'd0)
      begin
        r_a = QUOT_MIN;
        r_b = '1;
      end
      run_cycle(r_a, r_b, ctl[0], div_mode_pkg::rem_mode_e'(ctl[1]),
                ctl[16:15] != 2'b00, ctl[19:17] != 3'b000,
                expected_result(r_a, r_b, ctl[0], div_mode_pkg::rem_mode_e'(ctl[1])));
    end

    // Remaining edges of the pipe latency for the last accepted operation
    repeat (LATENCY - 1) run_cycle('0, '0, 1'b0, MODE_TRUNC, 1'b1, 1'b0, '0);

    if (expected_q.size() != 0)
    begin
      $display("Error: %0d operations did not produce a result in time", expected_q.size());
      abort_run();
    end
    else
    begin
      // Idle cycles must stay quiet
      repeat (4) run_cycle('0, '0, 1'b0, MODE_TRUNC, 1'b1, 1'b0, '0);
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
+incdir+design
design/div_mode_pkg.sv
design/div_data_pkg.sv
design/div_operand_prep.sv
design/div_stage.sv
design/div_result_fix.sv
design/div_pipe.sv
sim/div_pipe_tb.sv
